//--- Bender.yml
package:
  name: tf_rom

sources:
  - include_dirs:
      - include
    files:
      - logic/tf_pkg.sv
      - logic/tf_base_reader.sv
      - logic/tf_const_lookup.sv
      - logic/tf_rom_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tf_rom_tb.sv

//--- flist.f
+incdir+include
logic/tf_pkg.sv
logic/tf_base_reader.sv
logic/tf_const_lookup.sv
logic/tf_rom_top.sv
tb/tf_rom_tb.sv

//--- include/tf_tables.svh
// base twiddles with one row per iteration depth.
// deeper rows carry a single word in column 0.
localparam tf_word_t tf_base_table [tf_depths][tf_max_lanes] = '{
    '{
        28'h3e3a2b0, 28'h442e7e8, 28'h1cff90a, 28'h6f76bcb,
        28'h19bf5d5, 28'h7dbe285, 28'h2646f0b, 28'h108822e,
        28'h09dbc38, 28'h698c44d, 28'h7f5e353, 28'h3d22f79,
        28'h259c593, 28'h0e25dd5, 28'h9884296, 28'h0000000
    },
    '{
        28'h339af8f, 28'h005a761, 28'h1cf41c6, 28'h1905fdb,
        28'h17fc5dd, 28'h120de63, 28'h9ac3146, 28'h372a390,
        28'h7aa4c57, 28'h1230ae7, 28'h6617b95, 28'h7cdff82,
        28'h68cdd99, 28'h86e7108, 28'h4454f67, 28'h0000000
    },
    '{
        28'h808a836, 28'h4fc14e6, 28'h4899ee9, 28'h8fcf14c,
        28'h17d1a3e, 28'h2b9bdb3, 28'h367537e, 28'h280df35,
        28'h1debef5, 28'h6cc01f1, 28'h68a1e5c, 28'h7e0af96,
        28'h4874eb9, 28'h760187e, 28'h66c411f, 28'h0000000
    },
    '{
        28'h33fe7d2, 28'h0122a49, 28'h8f3339a, 28'h66fc73b,
        28'h4bc73ea, 28'h88a9d60, 28'h9b086e1, 28'h44f23cb,
        28'h963090d, 28'h78486cd, 28'h044ea3e, 28'h093bab2,
        28'h55189ed, 28'h6fcdb71, 28'h62fa6b8, 28'h0000000
    },
    '{
        0:       28'h7b37359,
        default: 28'h0
    },
    '{
        0:       28'h233dfb3,
        default: 28'h0
    },
    '{
        0:       28'h78d13f9,
        default: 28'h0
    },
    '{
        0:       28'h7371c04,
        default: 28'h0
    }
};

// constant twiddles for the a, a^2 and a^4 roots.
localparam tf_word_t tf_const_table [level_a:level_a4][tf_max_lanes] = '{
    '{
        28'h7b37359, 28'h280df35, 28'h8fcf14c, 28'h4fc14e6,
        28'h808a836, 28'h372a390, 28'h1905fdb, 28'h005a761,
        28'h339af8f, 28'h108822e, 28'h6f76bcb, 28'h442e7e8,
        28'h3e3a2b0, 28'h0000001, 28'h0000000, 28'h0000000
    },
    '{
        28'h280df35, 28'h8fcf14c, 28'h4fc14e6, 28'h808a836,
        28'h372a390, 28'h1905fdb, 28'h005a761, 28'h339af8f,
        28'h108822e, 28'h6f76bcb, 28'h442e7e8, 28'h3e3a2b0,
        28'ha000000, 28'h0000001, 28'h0000000, 28'h0000000
    },
    '{
        28'h8fcf14c, 28'h4fc14e6, 28'h808a836, 28'h372a390,
        28'h1905fdb, 28'h005a761, 28'h339af8f, 28'h108822e,
        28'h6f76bcb, 28'h442e7e8, 28'h3e3a2b0, 28'ha000000,
        28'h0000001, 28'h0000001, 28'h0000000, 28'h0000000
    }
};

//--- logic/tf_base_reader.sv
`timescale 1ns/1ns

module tf_base_reader #(
    parameter int lane_count = 15
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                tf_ren,
    input  tf_pkg::tf_depth_t   it_depth,
    output tf_pkg::tf_lanes_t   base_out
);

    import tf_pkg::*;

`include "tf_tables.svh"

    tf_lanes_t row_sel;

    // row for this depth with unused lanes forced low.
    always_comb begin
        row_sel = '0;
        for (int i = 0; i < tf_max_lanes - 1; i++) begin
            if (i < lane_count) begin
                row_sel.lane[i] = tf_base_table[it_depth][i];
            end
        end
    end

    // one cycle after the strobe.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            base_out <= '0;
        end else if (tf_ren) begin
            base_out <= row_sel;
        end
    end

endmodule

//--- logic/tf_const_lookup.sv
`timescale 1ns/1ns

module tf_const_lookup #(
    parameter int lane_count = 15
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                tf_ren,
    input  logic [2:0]          level,
    input  tf_pkg::tf_idx_t     lane_idx,
    output tf_pkg::tf_lanes_t   const_out
);

    import tf_pkg::*;

`include "tf_tables.svh"

    tf_level_e level_sel;
    tf_lanes_t const_sel;

    assign level_sel = level_decode(level); // 2 and 4 are special.

    // each lane reads its own column of the selected row.
    always_comb begin
        const_sel = '0;
        for (int i = 0; i < tf_max_lanes - 1; i++) begin
            if (i < lane_count) begin
                const_sel.lane[i] = tf_const_table[level_sel][lane_idx.idx[i]];
            end
        end
    end

    // holds while the strobe is low.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            const_out <= '0;
        end else if (tf_ren) begin
            const_out <= const_sel;
        end
    end

endmodule

//--- logic/tf_pkg.sv
package tf_pkg;

    localparam int tf_width     = 28;
    localparam int tf_max_lanes = 16; // last column is a pad.
    localparam int tf_depths    = 8;

    typedef logic [tf_width-1:0] tf_word_t;
    typedef logic [2:0]          tf_depth_t;
    typedef logic [3:0]          tf_col_t;

    // one result row with lane 0 in the low bits.
    typedef struct packed {
        tf_word_t [tf_max_lanes-2:0] lane;
    } tf_lanes_t;

    typedef struct packed {
        tf_col_t [tf_max_lanes-2:0] idx; // per-lane column.
    } tf_idx_t;

    // root power of the constant table.
    typedef enum logic [1:0] {
        level_a  = 2'd0,
        level_a2 = 2'd1,
        level_a4 = 2'd2
    } tf_level_e;

    function automatic tf_level_e level_decode(
        input logic [2:0] level
    );
        tf_level_e sel;
        case (level)
            3'd2: begin
                sel = level_a2;
            end
            3'd4: begin
                sel = level_a4;
            end
            default: begin
                sel = level_a; // every other level.
            end
        endcase
        return sel;
    endfunction

endpackage

//--- logic/tf_rom_top.sv
`timescale 1ns/1ns

module tf_rom_top #(
    parameter int lane_count = 15
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                tf_ren,
    input  tf_pkg::tf_depth_t   it_depth,
    input  logic [2:0]          level,
    input  tf_pkg::tf_idx_t     lane_idx,
    output tf_pkg::tf_lanes_t   base_out,
    output tf_pkg::tf_lanes_t   const_out
);

    // base row by iteration depth.
    tf_base_reader #(
        .lane_count (lane_count)
    ) base_reader_i (
        .clk      (clk),
        .rst      (rst),
        .tf_ren   (tf_ren),
        .it_depth (it_depth),
        .base_out (base_out)
    );

    // constant words by level and lane index.
    tf_const_lookup #(
        .lane_count (lane_count)
    ) const_lookup_i (
        .clk       (clk),
        .rst       (rst),
        .tf_ren    (tf_ren),
        .level     (level),
        .lane_idx  (lane_idx),
        .const_out (const_out)
    );

endmodule

//--- tb/tf_rom_tb.sv
`timescale 1ns/1ns

module tf_rom_tb;

    import tf_pkg::*;

`include "tf_tables.svh"

    localparam int lane_count    = tf_max_lanes - 1;
    localparam int trace_reads   = 28;
    localparam int random_reads  = 200;
    localparam int record_fields = 3 + 3 * lane_count; // ctrl, indices, two result rows.
    localparam int clk_period    = 4;

    logic        clk;
    logic        rst;
    logic        tf_ren;
    tf_depth_t   it_depth;
    logic [2:0]  level;
    tf_idx_t     lane_idx;
    tf_lanes_t   base_out;
    tf_lanes_t   const_out;

    tf_word_t    trace_mem [trace_reads * record_fields];
    tf_word_t    exp_base  [lane_count];
    tf_word_t    exp_const [lane_count];
    logic [31:0] lcg_state;
    int          errors;
    int          checks;

    tf_rom_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .tf_ren    (tf_ren),
        .it_depth  (it_depth),
        .level     (level),
        .lane_idx  (lane_idx),
        .base_out  (base_out),
        .const_out (const_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    // budget covers reset, the trace and the random reads.
    initial begin
        #((trace_reads + random_reads + 20) * clk_period);
        $display("timeout: the run did not finish in the expected time");
        $display("Regression failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(
        input string    name,
        input tf_word_t got,
        input tf_word_t expected
    );
        checks++;
        if (got !== expected) begin
            errors++;
            $display("** Error: %s is %h, expected %h", name, got, expected);
        end
    endtask

    task automatic verify_lanes();
        for (int i = 0; i < lane_count; i++) begin
            check_value($sformatf("base_out.lane[%0d]", i), base_out.lane[i], exp_base[i]);
            check_value($sformatf("const_out.lane[%0d]", i), const_out.lane[i],
                        exp_const[i]);
        end
    endtask

    task automatic drive_read(
        input logic       ren,
        input tf_depth_t  depth,
        input logic [2:0] lvl,
        input tf_idx_t    idx
    );
        tf_ren   = ren;
        it_depth = depth;
        level    = lvl;
        lane_idx = idx;
    endtask

    // reference model straight from the tables.
    task automatic model_read(
        input tf_depth_t  depth,
        input logic [2:0] lvl,
        input tf_idx_t    idx
    );
        tf_level_e row;
        if (lvl == 3'd2) begin
            row = level_a2;
        end else if (lvl == 3'd4) begin
            row = level_a4;
        end else begin
            row = level_a;
        end
        for (int i = 0; i < lane_count; i++) begin
            exp_base[i]  = tf_base_table[depth][i];
            exp_const[i] = tf_const_table[row][idx.idx[i]];
        end
    endtask

    task automatic load_trace(output bit ok);
        int fd;
        ok = 1'b0;
        fd = $fopen("tb/tf_rom_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file tb/tf_rom_trace.txt");
        end else begin
            $fclose(fd);
            $readmemh("tb/tf_rom_trace.txt", trace_mem);
            if ($isunknown(trace_mem[trace_reads * record_fields - 1])) begin
                $display("the trace file holds fewer than %0d reads", trace_reads);
            end else begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic replay_trace();
        int      at;
        tf_idx_t idx;
        for (int r = 0; r < trace_reads; r++) begin
            at = r * record_fields;
            for (int i = 0; i < lane_count; i++) begin
                idx.idx[i] = trace_mem[at + 3 + i][3:0];
            end
            drive_read(trace_mem[at][0], trace_mem[at + 1][2:0], trace_mem[at + 2][2:0], idx);
            for (int i = 0; i < lane_count; i++) begin
                exp_base[i]  = trace_mem[at + 3 + lane_count + i];
                exp_const[i] = trace_mem[at + 3 + 2 * lane_count + i];
            end
            @(negedge clk);
            verify_lanes();
        end
    endtask

    task automatic run_random_reads();
        tf_depth_t  depth;
        logic [2:0] lvl;
        tf_idx_t    idx;
        for (int n = 0; n < random_reads; n++) begin
            lcg_state = lcg_next(lcg_state);
            depth     = lcg_state[18:16];
            lvl       = lcg_state[22:20];
            for (int i = 0; i < lane_count; i++) begin
                lcg_state  = lcg_next(lcg_state);
                idx.idx[i] = lcg_state[19:16];
            end
            drive_read(1'b1, depth, lvl, idx);
            model_read(depth, lvl, idx);
            @(negedge clk);
            verify_lanes();
        end
    endtask

    initial begin
        bit trace_ok;
        rst       = 1'b1;
        tf_ren    = 1'b0;
        it_depth  = '0;
        level     = '0;
        lane_idx  = '0;
        errors    = 0;
        checks    = 0;
        lcg_state = 32'd73806;
        load_trace(trace_ok);
        if (!trace_ok) begin
            $display("Regression failed");
            $finish;
        end else begin
            repeat (5) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            for (int i = 0; i < lane_count; i++) begin
                exp_base[i]  = '0;
                exp_const[i] = '0;
            end
            verify_lanes(); // nothing strobed yet.
            replay_trace();
            run_random_reads();
            $display("checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
            $finish;
        end
    end

endmodule

//--- tb/tf_rom_trace.txt
// columns: strobe depth level, 15 lane indices (lane 0 first),
// then 15 expected base_out words and 15 expected const_out words
1 0 0 0 1 2 3 4 5 6 7 8 9 a b c d e 3e3a2b0 442e7e8 1cff90a 6f76bcb 19bf5d5 7dbe285 2646f0b 108822e 09dbc38 698c44d 7f5e353 3d22f79 259c593 0e25dd5 9884296 7b37359 280df35 8fcf14c 4fc14e6 808a836 372a390 1905fdb 005a761 339af8f 108822e 6f76bcb 442e7e8 3e3a2b0 0000001 0000000
1 1 2 0 1 2 3 4 5 6 7 8 9 a b c d e 339af8f 005a761 1cf41c6 1905fdb 17fc5dd 120de63 9ac3146 372a390 7aa4c57 1230ae7 6617b95 7cdff82 68cdd99 86e7108 4454f67 280df35 8fcf14c 4fc14e6 808a836 372a390 1905fdb 005a761 339af8f 108822e 6f76bcb 442e7e8 3e3a2b0 a000000 0000001 0000000
1 2 4 0 1 2 3 4 5 6 7 8 9 a b c d e 808a836 4fc14e6 4899ee9 8fcf14c 17d1a3e 2b9bdb3 367537e 280df35 1debef5 6cc01f1 68a1e5c 7e0af96 4874eb9 760187e 66c411f 8fcf14c 4fc14e6 808a836 372a390 1905fdb 005a761 339af8f 108822e 6f76bcb 442e7e8 3e3a2b0 a000000 0000001 0000001 0000000
1 3 1 1 2 3 4 5 6 7 8 9 a b c d e f 33fe7d2 0122a49 8f3339a 66fc73b 4bc73ea 88a9d60 9b086e1 44f23cb 963090d 78486cd 044ea3e 093bab2 55189ed 6fcdb71 62fa6b8 280df35 8fcf14c 4fc14e6 808a836 372a390 1905fdb 005a761 339af8f 108822e 6f76bcb 442e7e8 3e3a2b0 0000001 0000000 0000000
1 4 3 1 2 3 4 5 6 7 8 9 a b c d e f 7b37359 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 280df35 8fcf14c 4fc14e6 808a836 372a390 1905fdb 005a761 339af8f 108822e 6f76bcb 442e7e8 3e3a2b0 0000001 0000000 0000000
1 5 5 f e d c b a 9 8 7 6 5 4 3 2 1 233dfb3 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000001 3e3a2b0 442e7e8 6f76bcb 108822e 339af8f 005a761 1905fdb 372a390 808a836 4fc14e6 8fcf14c 280df35
1 6 6 f e d c b a 9 8 7 6 5 4 3 2 1 78d13f9 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000001 3e3a2b0 442e7e8 6f76bcb 108822e 339af8f 005a761 1905fdb 372a390 808a836 4fc14e6 8fcf14c 280df35
1 7 7 0 1 2 3 4 5 6 7 8 9 a b c d e 7371c04 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 7b37359 280df35 8fcf14c 4fc14e6 808a836 372a390 1905fdb 005a761 339af8f 108822e 6f76bcb 442e7e8 3e3a2b0 0000001 0000000
0 2 4 f f f f f f f f f f f f f f f 7371c04 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 7b37359 280df35 8fcf14c 4fc14e6 808a836 372a390 1905fdb 005a761 339af8f 108822e 6f76bcb 442e7e8 3e3a2b0 0000001 0000000
0 0 2 1 2 3 4 5 6 7 8 9 a b c d e f 7371c04 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 7b37359 280df35 8fcf14c 4fc14e6 808a836 372a390 1905fdb 005a761 339af8f 108822e 6f76bcb 442e7e8 3e3a2b0 0000001 0000000
1 0 2 f e d c b a 9 8 7 6 5 4 3 2 1 3e3a2b0 442e7e8 1cff90a 6f76bcb 19bf5d5 7dbe285 2646f0b 108822e 09dbc38 698c44d 7f5e353 3d22f79 259c593 0e25dd5 9884296 0000000 0000000 0000001 a000000 3e3a2b0 442e7e8 6f76bcb 108822e 339af8f 005a761 1905fdb 372a390 808a836 4fc14e6 8fcf14c
1 1 4 1 2 3 4 5 6 7 8 9 a b c d e f 339af8f 005a761 1cf41c6 1905fdb 17fc5dd 120de63 9ac3146 372a390 7aa4c57 1230ae7 6617b95 7cdff82 68cdd99 86e7108 4454f67 4fc14e6 808a836 372a390 1905fdb 005a761 339af8f 108822e 6f76bcb 442e7e8 3e3a2b0 a000000 0000001 0000001 0000000 0000000
1 2 0 f f f f f f f f f f f f f f f 808a836 4fc14e6 4899ee9 8fcf14c 17d1a3e 2b9bdb3 367537e 280df35 1debef5 6cc01f1 68a1e5c 7e0af96 4874eb9 760187e 66c411f 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000
1 3 4 f e d c b a 9 8 7 6 5 4 3 2 1 33fe7d2 0122a49 8f3339a 66fc73b 4bc73ea 88a9d60 9b086e1 44f23cb 963090d 78486cd 044ea3e 093bab2 55189ed 6fcdb71 62fa6b8 0000000 0000000 0000001 0000001 a000000 3e3a2b0 442e7e8 6f76bcb 108822e 339af8f 005a761 1905fdb 372a390 808a836 4fc14e6
0 7 1 0 1 2 3 4 5 6 7 8 9 a b c d e 33fe7d2 0122a49 8f3339a 66fc73b 4bc73ea 88a9d60 9b086e1 44f23cb 963090d 78486cd 044ea3e 093bab2 55189ed 6fcdb71 62fa6b8 0000000 0000000 0000001 0000001 a000000 3e3a2b0 442e7e8 6f76bcb 108822e 339af8f 005a761 1905fdb 372a390 808a836 4fc14e6
1 4 2 1 2 3 4 5 6 7 8 9 a b c d e f 7b37359 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 8fcf14c 4fc14e6 808a836 372a390 1905fdb 005a761 339af8f 108822e 6f76bcb 442e7e8 3e3a2b0 a000000 0000001 0000000 0000000
1 5 4 c d 0 f 3 3 b 7 1 e 2 9 5 8 4 233dfb3 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000001 0000001 8fcf14c 0000000 372a390 372a390 a000000 108822e 4fc14e6 0000000 808a836 442e7e8 005a761 6f76bcb 1905fdb
1 6 0 c d 0 f 3 3 b 7 1 e 2 9 5 8 4 78d13f9 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 3e3a2b0 0000001 7b37359 0000000 4fc14e6 4fc14e6 442e7e8 005a761 280df35 0000000 8fcf14c 108822e 372a390 339af8f 808a836
1 7 2 c d 0 f 3 3 b 7 1 e 2 9 5 8 4 7371c04 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 a000000 0000001 280df35 0000000 808a836 808a836 3e3a2b0 339af8f 8fcf14c 0000000 4fc14e6 6f76bcb 1905fdb 108822e 372a390
0 1 4 f e d c b a 9 8 7 6 5 4 3 2 1 7371c04 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 a000000 0000001 280df35 0000000 808a836 808a836 3e3a2b0 339af8f 8fcf14c 0000000 4fc14e6 6f76bcb 1905fdb 108822e 372a390
0 3 5 f f f f f f f f f f f f f f f 7371c04 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 a000000 0000001 280df35 0000000 808a836 808a836 3e3a2b0 339af8f 8fcf14c 0000000 4fc14e6 6f76bcb 1905fdb 108822e 372a390
1 0 6 c d 0 f 3 3 b 7 1 e 2 9 5 8 4 3e3a2b0 442e7e8 1cff90a 6f76bcb 19bf5d5 7dbe285 2646f0b 108822e 09dbc38 698c44d 7f5e353 3d22f79 259c593 0e25dd5 9884296 3e3a2b0 0000001 7b37359 0000000 4fc14e6 4fc14e6 442e7e8 005a761 280df35 0000000 8fcf14c 108822e 372a390 339af8f 808a836
1 1 3 f f f f f f f f f f f f f f f 339af8f 005a761 1cf41c6 1905fdb 17fc5dd 120de63 9ac3146 372a390 7aa4c57 1230ae7 6617b95 7cdff82 68cdd99 86e7108 4454f67 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000
1 2 5 1 2 3 4 5 6 7 8 9 a b c d e f 808a836 4fc14e6 4899ee9 8fcf14c 17d1a3e 2b9bdb3 367537e 280df35 1debef5 6cc01f1 68a1e5c 7e0af96 4874eb9 760187e 66c411f 280df35 8fcf14c 4fc14e6 808a836 372a390 1905fdb 005a761 339af8f 108822e 6f76bcb 442e7e8 3e3a2b0 0000001 0000000 0000000
1 3 7 f e d c b a 9 8 7 6 5 4 3 2 1 33fe7d2 0122a49 8f3339a 66fc73b 4bc73ea 88a9d60 9b086e1 44f23cb 963090d 78486cd 044ea3e 093bab2 55189ed 6fcdb71 62fa6b8 0000000 0000000 0000001 3e3a2b0 442e7e8 6f76bcb 108822e 339af8f 005a761 1905fdb 372a390 808a836 4fc14e6 8fcf14c 280df35
1 4 4 0 1 2 3 4 5 6 7 8 9 a b c d e 7b37359 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 8fcf14c 4fc14e6 808a836 372a390 1905fdb 005a761 339af8f 108822e 6f76bcb 442e7e8 3e3a2b0 a000000 0000001 0000001 0000000
1 5 2 f f f f f f f f f f f f f f f 233dfb3 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000
1 6 1 0 1 2 3 4 5 6 7 8 9 a b c d e 78d13f9 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 7b37359 280df35 8fcf14c 4fc14e6 808a836 372a390 1905fdb 005a761 339af8f 108822e 6f76bcb 442e7e8 3e3a2b0 0000001 0000000
